// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_top
OBJ_DIR ?= obj_dir
FILELIST ?= sim.f
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/stat_ctrl_fsm.sv ====
// Table controller FSM
`timescale 1ns/1ps

module stat_ctrl_fsm
(
    input  logic clk,
    input  logic reset,
    input  logic clear_all,
    input  logic busy,
    input  logic sweep_done,
    output logic sweep_start,
    output logic ready
);

    stat_pkg::state_e state;
    stat_pkg::state_e state_next;
    logic             start_next;

    // Next state and sweep start request
    always_comb
    begin
        state_next = state;
        start_next = 1'b0;

        case (state)
            stat_pkg::ST_SWEEP:
            begin
                // A clear arriving on the final sweep cycle still gets its own sweep
                if (sweep_done)
                begin
                    state_next = clear_all ? stat_pkg::ST_DRAIN : stat_pkg::ST_RUN;
                end
            end

            stat_pkg::ST_RUN:
            begin
                if (clear_all)
                begin
                    state_next = stat_pkg::ST_DRAIN;
                end
            end

            stat_pkg::ST_DRAIN:
            begin
                // Wait until no update can still reach the RAM
                if (!busy)
                begin
                    state_next = stat_pkg::ST_SWEEP;
                    start_next = 1'b1;
                end
            end

            default:
            begin
                state_next = stat_pkg::ST_SWEEP;
                start_next = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Leaving reset kicks off the initial sweep straight away
            state <= stat_pkg::ST_SWEEP;
            sweep_start <= 1'b1;
        end
        else
        begin
            state <= state_next;
            sweep_start <= start_next;
        end
    end

    // Commands are only taken in the run state
    assign ready = (state == stat_pkg::ST_RUN);

endmodule

// ==== hw/stat_pkg.sv ====
// Statistics table definitions
package stat_pkg;

    // Table geometry shared by every block and by the structs below
    parameter int N_ENTRIES = 32;
    parameter int IDX_BITS = $clog2(N_ENTRIES);
    parameter int COUNT_BITS = 16;
    parameter int AMT_BITS = 8;

    // Counters stop at all ones instead of wrapping
    parameter logic [COUNT_BITS-1:0] COUNT_MAX = '1;

    // Command opcodes
    typedef enum logic [1:0] {
        OP_ADD        = 2'd0,
        OP_READ       = 2'd1,
        OP_READ_CLEAR = 2'd2
    } opcode_e;

    // Controller states
    typedef enum logic [1:0] {
        ST_SWEEP = 2'd0,
        ST_RUN   = 2'd1,
        ST_DRAIN = 2'd2
    } state_e;

    // One command on the input stream
    typedef struct packed {
        opcode_e               op;
        logic [IDX_BITS-1:0]   index;
        logic [AMT_BITS-1:0]   amount;
    } stat_cmd_t;

    // Response to a read, carrying the value before the command was applied
    typedef struct packed {
        opcode_e               op;
        logic [IDX_BITS-1:0]   index;
        logic [COUNT_BITS-1:0] value;
    } stat_rsp_t;

    // A single RAM write port
    typedef struct packed {
        logic                  wen;
        logic [IDX_BITS-1:0]   addr;
        logic [COUNT_BITS-1:0] data;
    } ram_wr_t;

endpackage

// ==== hw/stat_ram.sv ====
// Counter table RAM
`timescale 1ns/1ps

module stat_ram
#(
    parameter int N_OUTPUT_REG_STAGES = 1
)
(
    input  logic                             clk,
    input  logic [stat_pkg::IDX_BITS-1:0]    raddr,
    output logic [stat_pkg::COUNT_BITS-1:0]  rdata,
    input  stat_pkg::ram_wr_t                upd_wr,
    input  stat_pkg::ram_wr_t                sweep_wr
);

    // Storage array, left to the tool to map onto block RAM
    logic [stat_pkg::COUNT_BITS-1:0] mem [0:stat_pkg::N_ENTRIES-1];

    // Write port after the sweep/update select
    stat_pkg::ram_wr_t wr_sel;

    // The write as it is held for one cycle before reaching the array
    stat_pkg::ram_wr_t wr_q;

    // Registered read, with the bypass flag and data captured alongside
    logic [stat_pkg::COUNT_BITS-1:0] mem_q;
    logic                            match_q;
    logic [stat_pkg::COUNT_BITS-1:0] byp_q;
    logic [stat_pkg::COUNT_BITS-1:0] rd_word;

    // The sweep owns the write port for as long as it runs
    assign wr_sel = sweep_wr.wen ? sweep_wr : upd_wr;

    // Hold every write one cycle, which eases timing on the write path
    always_ff @(posedge clk)
    begin
        wr_q <= wr_sel;
    end

    // Array write from the delayed port
    always_ff @(posedge clk)
    begin
        if (wr_q.wen)
        begin
            mem[wr_q.addr] <= wr_q.data;
        end
    end

    // Array read returns old data when it lands on the same edge as a write,
    // so the delayed write is captured here and substituted after the read
    always_ff @(posedge clk)
    begin
        mem_q <= mem[raddr];
        match_q <= wr_q.wen && (wr_q.addr == raddr);
        byp_q <= wr_q.data;
    end

    assign rd_word = match_q ? byp_q : mem_q;

    // Optional output register stages behind the read register
    generate
        if (N_OUTPUT_REG_STAGES == 0)
        begin : g_no_out
            assign rdata = rd_word;
        end
        else
        begin : g_out
            logic [stat_pkg::COUNT_BITS-1:0] out_q [1:N_OUTPUT_REG_STAGES];

            always_ff @(posedge clk)
            begin
                out_q[1] <= rd_word;
                // Plain shift through the remaining stages
                for (int s = 2; s <= N_OUTPUT_REG_STAGES; s++)
                begin
                    out_q[s] <= out_q[s-1];
                end
            end

            assign rdata = out_q[N_OUTPUT_REG_STAGES];
        end
    endgenerate

endmodule

// ==== hw/stat_table_top.sv ====
// Statistics counter table
`timescale 1ns/1ps

module stat_table_top
#(
    parameter int N_OUTPUT_REG_STAGES = 1
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  stat_pkg::stat_cmd_t cmd,
    input  logic                clear_all,
    output logic                ready,
    output logic                rsp_valid,
    output stat_pkg::stat_rsp_t rsp
);

    // Controller to sweep counter
    logic sweep_start;
    logic sweep_done;

    // Write ports into the RAM
    stat_pkg::ram_wr_t sweep_wr;
    stat_pkg::ram_wr_t upd_wr;

    // Read port between pipeline and RAM
    logic [stat_pkg::IDX_BITS-1:0]   raddr;
    logic [stat_pkg::COUNT_BITS-1:0] rdata;

    // Pipeline occupancy, used to hold off the sweep
    logic busy;

    stat_ctrl_fsm ctrl0
    (
        .clk         (clk),
        .reset       (reset),
        .clear_all   (clear_all),
        .busy        (busy),
        .sweep_done  (sweep_done),
        .sweep_start (sweep_start),
        .ready       (ready)
    );

    sweep_counter sweep0
    (
        .clk      (clk),
        .reset    (reset),
        .start    (sweep_start),
        .sweep_wr (sweep_wr),
        .done     (sweep_done)
    );

    stat_ram #(.N_OUTPUT_REG_STAGES(N_OUTPUT_REG_STAGES)) ram0
    (
        .clk      (clk),
        .raddr    (raddr),
        .rdata    (rdata),
        .upd_wr   (upd_wr),
        .sweep_wr (sweep_wr)
    );

    stat_update_pipe #(.N_OUTPUT_REG_STAGES(N_OUTPUT_REG_STAGES)) pipe0
    (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .ready     (ready),
        .raddr     (raddr),
        .rdata     (rdata),
        .upd_wr    (upd_wr),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

// ==== hw/stat_update_pipe.sv ====
// Counter update pipeline
`timescale 1ns/1ps

module stat_update_pipe
#(
    parameter int N_OUTPUT_REG_STAGES = 1
)
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cmd_valid,
    input  stat_pkg::stat_cmd_t             cmd,
    input  logic                            ready,
    output logic [stat_pkg::IDX_BITS-1:0]   raddr,
    input  logic [stat_pkg::COUNT_BITS-1:0] rdata,
    output stat_pkg::ram_wr_t               upd_wr,
    output logic                            busy,
    output logic                            rsp_valid,
    output stat_pkg::stat_rsp_t             rsp
);

    // Edges from the address leaving the command register to data at rdata
    localparam int RD_LAT = N_OUTPUT_REG_STAGES + 1;

    // Writes issued but not yet visible to a read that is in flight
    localparam int HIST_DEPTH = N_OUTPUT_REG_STAGES + 2;

    // Stage 0 is the command register, stage RD_LAT lines up with rdata
    logic [RD_LAT:0]      pv;
    stat_pkg::stat_cmd_t  pc [0:RD_LAT];

    // Recent writes, youngest first; entry 0 is the write on the RAM port now
    stat_pkg::ram_wr_t    hist [0:HIST_DEPTH-1];

    logic                              accept;
    stat_pkg::stat_cmd_t               cur;
    logic [stat_pkg::COUNT_BITS-1:0]   base;
    logic [stat_pkg::COUNT_BITS:0]     sum;
    logic [stat_pkg::COUNT_BITS-1:0]   new_value;
    logic                              wr_en;
    logic                              rsp_fire;

    assign accept = cmd_valid && ready;

    // Valid bits travel with the payload and are the only part that is reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pv <= '0;
        end
        else
        begin
            pv <= {pv[RD_LAT-1:0], accept};
        end
    end

    always_ff @(posedge clk)
    begin
        pc[0] <= cmd;
        for (int k = 1; k <= RD_LAT; k++)
        begin
            pc[k] <= pc[k-1];
        end
    end

    // The RAM is addressed from the command register
    assign raddr = pc[0].index;

    assign cur = pc[RD_LAT];

    // Pick the youngest write to this index that the RAM read could not see.
    // The loop runs oldest to youngest so later matches override earlier ones
    always_comb
    begin
        base = rdata;
        for (int k = HIST_DEPTH - 1; k >= 0; k--)
        begin
            if (hist[k].wen && (hist[k].addr == cur.index))
            begin
                base = hist[k].data;
            end
        end
    end

    // Extra top bit catches the carry for saturation
    assign sum = {1'b0, base} +
                 {{(stat_pkg::COUNT_BITS + 1 - stat_pkg::AMT_BITS){1'b0}}, cur.amount};

    always_comb
    begin
        case (cur.op)
            stat_pkg::OP_ADD:
                new_value = sum[stat_pkg::COUNT_BITS] ? stat_pkg::COUNT_MAX :
                                                        sum[stat_pkg::COUNT_BITS-1:0];
            stat_pkg::OP_READ:
                new_value = base;
            stat_pkg::OP_READ_CLEAR:
                new_value = '0;
            default:
                new_value = base;
        endcase
    end

    // A plain read leaves the counter alone, so it needs no write
    assign wr_en = pv[RD_LAT] && (cur.op != stat_pkg::OP_READ);
    assign rsp_fire = pv[RD_LAT] &&
                      ((cur.op == stat_pkg::OP_READ) || (cur.op == stat_pkg::OP_READ_CLEAR));

    // Compute register. The history shifts every cycle so an idle cycle ages it
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid <= 1'b0;
            for (int k = 0; k < HIST_DEPTH; k++)
            begin
                hist[k] <= '0;
            end
        end
        else
        begin
            rsp_valid <= rsp_fire;
            hist[0] <= '{wen: wr_en, addr: cur.index, data: new_value};
            for (int k = 1; k < HIST_DEPTH; k++)
            begin
                hist[k] <= hist[k-1];
            end
        end
    end

    // Response payload reports the value before the command
    always_ff @(posedge clk)
    begin
        rsp <= '{op: cur.op, index: cur.index, value: base};
    end

    // The write leaves together with the response
    assign upd_wr = hist[0];

    // Anything still in a stage, or a write still on the port, counts as busy
    assign busy = (|pv) || rsp_valid || hist[0].wen;

endmodule

// ==== hw/sweep_counter.sv ====
// Table sweep counter
`timescale 1ns/1ps

module sweep_counter
(
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    output stat_pkg::ram_wr_t sweep_wr,
    output logic              done
);

    // Sweep in progress
    logic active;

    // Entry being zeroed this cycle
    logic [stat_pkg::IDX_BITS-1:0] addr;

    // Last entry of the table
    logic last;

    assign last = (addr == stat_pkg::IDX_BITS'(stat_pkg::N_ENTRIES - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active <= 1'b0;
            addr <= '0;
        end
        else if (start)
        begin
            // A new start always begins from entry zero
            active <= 1'b1;
            addr <= '0;
        end
        else if (active)
        begin
            if (last)
            begin
                active <= 1'b0;
            end
            else
            begin
                addr <= addr + 1'b1;
            end
        end
    end

    // One zero write per cycle while active, none when idle
    assign sweep_wr = '{wen: active, addr: addr, data: '0};

    // Pulses with the final write
    assign done = active && last;

endmodule

// ==== sim.f ====
hw/stat_pkg.sv
hw/stat_ram.sv
hw/sweep_counter.sv
hw/stat_ctrl_fsm.sv
hw/stat_update_pipe.sv
hw/stat_table_top.sv
test/tb_clock.sv
test/stat_table_properties.sv
test/tb_checker.sv
test/tb_top.sv

// ==== test/stat_table_properties.sv ====
// Counter table assertions
`timescale 1ns/1ps

module stat_table_properties
(
    input logic              clk,
    input logic              reset,
    input logic              clear_all,
    input logic              ready,
    input logic              rsp_valid,
    input stat_pkg::state_e  state,
    input logic              sweep_wen,
    input logic              upd_wen
);

    // No response can come out while the table is being zeroed
    assert property (@(posedge clk) disable iff (reset)
        (state == stat_pkg::ST_SWEEP) |-> !rsp_valid)
        else $error("Response seen during the sweep");

    // A clear always closes the command stream on the next edge
    assert property (@(posedge clk) disable iff (reset)
        clear_all |=> !ready)
        else $error("Ready still high after clear_all");

    // The drain before each sweep keeps the two writers apart
    assert property (@(posedge clk) disable iff (reset)
        !(sweep_wen && upd_wen))
        else $error("Sweep write and update write enabled together");

endmodule

bind stat_table_top stat_table_properties props0
(
    .clk       (clk),
    .reset     (reset),
    .clear_all (clear_all),
    .ready     (ready),
    .rsp_valid (rsp_valid),
    .state     (ctrl0.state),
    .sweep_wen (sweep_wr.wen),
    .upd_wen   (upd_wr.wen)
);

// ==== test/tb_checker.sv ====
// Counter table response checker
`timescale 1ns/1ps

module tb_checker
(
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  stat_pkg::stat_cmd_t cmd,
    input  logic                clear_all,
    input  logic                ready,
    input  logic                rsp_valid,
    input  stat_pkg::stat_rsp_t rsp,
    input  logic [8*16-1:0]     test_name,
    input  logic                test_done,
    output int                  error_count,
    output int                  tests_run
);

    // Model of every counter, updated at the accept edge
    logic [stat_pkg::COUNT_BITS-1:0] model [0:stat_pkg::N_ENTRIES-1];

    // Responses still owed by the DUT, oldest first
    stat_pkg::stat_rsp_t expected_q [$];
    stat_pkg::stat_rsp_t exp_rsp;

    int errors = 0;
    int runs = 0;
    int errors_at_start = 0;

    // Edges that ready has been seen low since it was last high
    int low_cycles = 0;

    assign error_count = errors;
    assign tests_run = runs;

    // Counter value after one command, saturating on add
    function automatic logic [stat_pkg::COUNT_BITS-1:0] next_count
    (
        input stat_pkg::opcode_e               op,
        input logic [stat_pkg::COUNT_BITS-1:0] old,
        input logic [stat_pkg::AMT_BITS-1:0]   amount
    );
        logic [stat_pkg::COUNT_BITS:0] total;
        total = {1'b0, old} + (stat_pkg::COUNT_BITS + 1)'(amount);
        case (op)
            stat_pkg::OP_ADD:        return total[stat_pkg::COUNT_BITS] ? '1 :
                                            total[stat_pkg::COUNT_BITS-1:0];
            stat_pkg::OP_READ_CLEAR: return '0;
            default:                 return old;
        endcase
    endfunction

    // Readable form of a response for the report lines
    function automatic string rsp_text(input stat_pkg::stat_rsp_t r);
        return $sformatf("op %0d index %0d value %0h", r.op, r.index, r.value);
    endfunction

    always @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < stat_pkg::N_ENTRIES; i++)
            begin
                model[i] = '0;
            end
            expected_q.delete();
            low_cycles = 0;
        end
        else
        begin
            // Ready may only return once a whole sweep has run, one entry per cycle
            if (ready)
            begin
                if ((low_cycles != 0) && (low_cycles < stat_pkg::N_ENTRIES))
                begin
                    $display("%0s: ready rose after only %0d low cycles",
                             test_name, low_cycles);
                    errors++;
                end
                low_cycles = 0;
            end
            else
            begin
                low_cycles++;
            end

            // Responses are compared in command order
            if (rsp_valid)
            begin
                if (expected_q.size() == 0)
                begin
                    $display("%0s: response for index %0d arrived with none expected",
                             test_name, rsp.index);
                    errors++;
                end
                else
                begin
                    exp_rsp = expected_q.pop_front();
                    if (rsp !== exp_rsp)
                    begin
                        $display("Fail %0s: expected %0s, actual %0s",
                                 test_name, rsp_text(exp_rsp), rsp_text(rsp));
                        errors++;
                    end
                end
            end

            // A read reports the value as it stood before the command
            if (cmd_valid && ready)
            begin
                if (cmd.op != stat_pkg::OP_ADD)
                begin
                    expected_q.push_back('{op: cmd.op, index: cmd.index,
                                           value: model[cmd.index]});
                end
                model[cmd.index] = next_count(cmd.op, model[cmd.index], cmd.amount);
            end

            // A command accepted on the clear edge still lands before the wipe
            if (clear_all)
            begin
                for (int i = 0; i < stat_pkg::N_ENTRIES; i++)
                begin
                    model[i] = '0;
                end
            end

            if (test_done)
            begin
                if (expected_q.size() != 0)
                begin
                    $display("%0s: %0d expected responses never arrived",
                             test_name, expected_q.size());
                    errors++;
                    expected_q.delete();
                end
                runs++;
                $display("Test %0s finished with %0d errors", test_name,
                         errors - errors_at_start);
                errors_at_start = errors;
            end
        end
    end

endmodule

// ==== test/tb_clock.sv ====
// Testbench clock source
`timescale 1ns/1ps

module tb_clock
(
    output logic clk
);

    // Half of the 4 ns period
    localparam realtime HALF_PERIOD = 2.0;

    initial
    begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

// ==== test/tb_top.sv ====
// Counter table testbench
`timescale 1ns/1ps

module tb_top;

    localparam int N_OUT = 1;
    localparam int LAT = N_OUT + 3;
    localparam int N_RANDOM = 200;
    localparam int N_SAT = 260;
    localparam int N_GAPS = LAT + 2;

    // Commands over all tests, sweeps and per-test drains, doubled for margin
    localparam int TOTAL_CMDS = 3 * stat_pkg::N_ENTRIES + N_RANDOM + 16 + N_SAT + 8 + 20 +
                                N_GAPS * (N_GAPS + 3) / 2;
    localparam int SWEEP_CYCLES = 2 * (stat_pkg::N_ENTRIES + 4);
    localparam int WATCHDOG_NS = 2 * 4 * (TOTAL_CMDS + SWEEP_CYCLES + 6 * (LAT + 4) + 4);

    logic                clk;
    logic                reset;
    logic                cmd_valid;
    stat_pkg::stat_cmd_t cmd;
    logic                clear_all;
    logic                ready;
    logic                rsp_valid;
    stat_pkg::stat_rsp_t rsp;
    logic [8*16-1:0]     test_name;
    logic                test_done;
    int                  error_count;
    int                  tests_run;
    int                  pick;

    tb_clock clk0 (.clk(clk));

    stat_table_top #(.N_OUTPUT_REG_STAGES(N_OUT)) dut0
    (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .clear_all (clear_all),
        .ready     (ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    tb_checker chk0
    (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .clear_all   (clear_all),
        .ready       (ready),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .test_name   (test_name),
        .test_done   (test_done),
        .error_count (error_count),
        .tests_run   (tests_run)
    );

    // Every task starts and ends 1 ns after a rising edge
    task automatic send(input stat_pkg::opcode_e op, input int idx, input int amt);
        cmd_valid = 1'b1;
        cmd = '{op: op, index: stat_pkg::IDX_BITS'(idx), amount: stat_pkg::AMT_BITS'(amt)};
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_ready();
        while (!ready)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic read_all();
        for (int i = 0; i < stat_pkg::N_ENTRIES; i++)
        begin
            send(stat_pkg::OP_READ, i, 0);
        end
    endtask

    // The fixed latency bounds the drain, so a few spare edges empty the pipeline
    task automatic end_test();
        repeat (LAT + 2) @(posedge clk);
        #1;
        test_done = 1'b1;
        @(posedge clk);
        #1;
        test_done = 1'b0;
    endtask

    initial
    begin
        void'($urandom(40));
        cmd_valid = 1'b0;
        cmd = '0;
        clear_all = 1'b0;
        test_done = 1'b0;
        test_name = "startup";
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        test_name = "reset_zero";
        wait_ready();
        read_all();
        end_test();

        test_name = "random_mix";
        for (int n = 0; n < N_RANDOM; n++)
        begin
            pick = $urandom_range(0, 7);
            if (pick < 5)
                send(stat_pkg::OP_ADD, $urandom_range(0, stat_pkg::N_ENTRIES - 1),
                     $urandom_range(0, 255));
            else if (pick < 7)
                send(stat_pkg::OP_READ, $urandom_range(0, stat_pkg::N_ENTRIES - 1), 0);
            else
                send(stat_pkg::OP_READ_CLEAR, $urandom_range(0, stat_pkg::N_ENTRIES - 1), 0);
        end
        read_all();
        end_test();

        // Alternating add and read on one index hits forwarding every cycle
        test_name = "same_index";
        for (int k = 0; k < 8; k++)
        begin
            send(stat_pkg::OP_ADD, 5, k + 1);
            send(stat_pkg::OP_READ, 5, 0);
        end
        // Widening gaps between an add and its read step through each forwarding
        // depth, then the RAM bypass, then a plain array read
        for (int g = 0; g < N_GAPS; g++)
        begin
            send(stat_pkg::OP_ADD, 5, 3 + g);
            repeat (g)
            begin
                @(posedge clk);
                #1;
            end
            send(stat_pkg::OP_READ, 5, 0);
        end
        end_test();

        test_name = "saturate";
        for (int k = 0; k < N_SAT; k++)
        begin
            send(stat_pkg::OP_ADD, 9, 255);
        end
        send(stat_pkg::OP_READ, 9, 0);
        send(stat_pkg::OP_ADD, 9, 1);
        send(stat_pkg::OP_READ, 9, 0);
        end_test();

        test_name = "read_clear";
        send(stat_pkg::OP_ADD, 12, 77);
        send(stat_pkg::OP_READ_CLEAR, 12, 0);
        send(stat_pkg::OP_READ, 12, 0);
        end_test();

        // Commands offered while ready is low must leave no trace
        test_name = "clear_all";
        for (int k = 0; k < 8; k++)
        begin
            send(stat_pkg::OP_ADD, k, 10 + k);
        end
        clear_all = 1'b1;
        send(stat_pkg::OP_ADD, 3, 5);
        clear_all = 1'b0;
        // Reads and adds keep coming through the drain and the whole sweep
        for (int k = 0; !ready; k++)
        begin
            if (k % 2 == 1)
            begin
                send(stat_pkg::OP_READ, k % stat_pkg::N_ENTRIES, 0);
            end
            else
            begin
                send(stat_pkg::OP_ADD, k % stat_pkg::N_ENTRIES, 200);
            end
        end
        read_all();
        end_test();

        $display("Tests run %0d, errors %0d", tests_run, error_count);
        if (error_count == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog against a DUT that never raises ready again
    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule
